// File: ads_patterns.txt
// op cmd addr wdata miso, one request per line, hex
// op 0 system command, 1 write register, 2 read register
0 02 00 00 00
0 08 00 00 00
1 00 01 02 00
2 00 01 00 a5
1 00 02 e0 00
0 0a 00 00 00
0 06 00 00 00
2 00 05 00 3c
2 00 0b 00 c3
0 08 00 00 00
1 00 1f 7e 00
0 04 00 00 00
2 00 11 00 81
0 0a 00 00 00
1 00 04 55 00
2 00 0a 00 5a

// File: src.f
ads_pkg.sv
ads_frame_builder.sv
ads_cs_sequencer.sv
ads_spi_shifter.sv
ads_controller.sv
tb_ads_spi_slave.sv
tb_ads_controller.sv

// File: Bender.yml
package:
  name: ads_controller

sources:
  - ads_pkg.sv
  - ads_frame_builder.sv
  - ads_cs_sequencer.sv
  - ads_spi_shifter.sv
  - ads_controller.sv
  - target: test
    files:
      - tb_ads_spi_slave.sv
      - tb_ads_controller.sv

// File: tb_ads_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ads_controller;

	localparam integer PATTERN_COUNT = 16;
	localparam integer FIELDS        = 5; // op cmd addr wdata miso
	localparam integer RESET_CYCLES  = 16;
	localparam integer CYCLE_LIMIT   = RESET_CYCLES + PATTERN_COUNT *
		(3 * 16 * ads_pkg::CLKS_PER_HALF_BIT + ads_pkg::CS_HOLD_CYCLES + 64);

	logic                        i_CLK;
	logic                        i_RSTN;
	logic                        i_req_valid;
	ads_pkg::ads_op_e            i_req_op;
	ads_pkg::ads_byte_t          i_req_cmd;
	ads_pkg::ads_reg_addr_t      i_req_addr;
	ads_pkg::ads_byte_t          i_req_wdata;
	logic                        i_rdata_ready;
	wire                         i_spi_miso;    // from the slave model
	wire                         o_req_ready;
	wire                         o_busy;
	wire ads_pkg::ads_byte_t     o_rdata;
	wire                         o_rdata_valid;
	wire                         o_ads_start;
	wire                         o_ads_resetn;
	wire                         o_spi_clk;
	wire                         o_spi_mosi;
	wire                         o_spi_csn;

	logic [7:0]                  pat_mem [0:PATTERN_COUNT*FIELDS-1];
	ads_pkg::ads_byte_t          slave_miso;
	wire [23:0]                  frame_bytes;
	wire [7:0]                   frame_len;
	wire [7:0]                   frame_cnt;
	integer                      seed_val;
	integer                      p;
	integer                      cycle_cnt        = 0;
	integer                      error_count      = 0;
	integer                      csn_falls        = 0;
	integer                      reset_pulses     = 0;
	integer                      reset_low_cnt    = 0;
	integer                      last_reset_width = 0;
	logic                        prev_csn         = 1'b1;
	logic                        exp_start;     // start pin level so far
	logic                        rdata_pending; // read byte not yet taken
	ads_pkg::ads_byte_t          exp_rdata;

	ads_controller ads_controller_inst (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_req_valid(i_req_valid), .i_req_op(i_req_op), .i_req_cmd(i_req_cmd),
		.i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
		.o_req_ready(o_req_ready), .o_busy(o_busy),
		.o_rdata(o_rdata), .o_rdata_valid(o_rdata_valid), .i_rdata_ready(i_rdata_ready),
		.o_ads_start(o_ads_start), .o_ads_resetn(o_ads_resetn),
		.o_spi_clk(o_spi_clk), .o_spi_mosi(o_spi_mosi), .o_spi_csn(o_spi_csn),
		.i_spi_miso(i_spi_miso)
	);

	tb_ads_spi_slave spi_slave (
		.i_spi_csn(o_spi_csn), .i_spi_clk(o_spi_clk), .i_spi_mosi(o_spi_mosi),
		.i_miso_byte(slave_miso), .o_spi_miso(i_spi_miso),
		.o_frame_bytes(frame_bytes), .o_frame_len(frame_len), .o_frame_cnt(frame_cnt)
	);

	always #4 i_CLK = ~i_CLK; // 8 ns period

	// ==================================================
	// monitors and cycle limit
	// ==================================================
	always begin
		@(posedge i_CLK);
		#1;
		if (prev_csn && !o_spi_csn) csn_falls = csn_falls + 1;
		prev_csn = o_spi_csn;
		if (!o_ads_resetn) begin
			reset_low_cnt = reset_low_cnt + 1;
		end else if (reset_low_cnt != 0) begin
			last_reset_width = reset_low_cnt; // pulse just ended
			reset_pulses     = reset_pulses + 1;
			reset_low_cnt    = 0;
		end
	end

	always @(posedge i_CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			abort_run($sformatf("cycle limit of %0d reached, DUT stopped responding", CYCLE_LIMIT));
		end
	end

	task automatic abort_run(input string why);
		error_count = error_count + 1;
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input ads_pkg::ads_byte_t got,
			input ads_pkg::ads_byte_t exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic tick;
		@(posedge i_CLK);
		#1; // drive and sample just after the edge
	endtask

	// ==================================================
	// host side
	// ==================================================
	task automatic send_request(input ads_pkg::ads_op_e op, input ads_pkg::ads_byte_t cmd,
			input ads_pkg::ads_reg_addr_t addr, input ads_pkg::ads_byte_t wdata);
		i_req_valid = 1'b1;
		i_req_op    = op;
		i_req_cmd   = cmd;
		i_req_addr  = addr;
		i_req_wdata = wdata;
		while (!o_req_ready) tick;
		tick; // transfer edge
		i_req_valid = 1'b0;
	endtask

	task automatic wait_idle;
		while (o_busy) begin
			check_bit("o_req_ready", o_req_ready, 1'b0);
			tick;
		end
		check_bit("o_req_ready", o_req_ready, 1'b1);
	endtask

	// read byte held back, nothing may start on the spi side meanwhile
	task automatic stall_rdata(input integer cycles, input logic exp_busy);
		repeat (cycles) begin
			check_bit("o_rdata_valid", o_rdata_valid, 1'b1);
			check_byte("o_rdata", o_rdata, exp_rdata);
			check_bit("o_spi_csn", o_spi_csn, 1'b1);
			check_bit("o_busy", o_busy, exp_busy);
			check_bit("o_req_ready", o_req_ready, ~exp_busy);
			tick;
		end
	endtask

	task automatic take_rdata;
		check_bit("o_rdata_valid", o_rdata_valid, 1'b1);
		check_byte("o_rdata", o_rdata, exp_rdata);
		i_rdata_ready = 1'b1;
		tick;
		i_rdata_ready = 1'b0;
		check_bit("o_rdata_valid", o_rdata_valid, 1'b0);
		rdata_pending = 1'b0;
	endtask

	task automatic run_pattern(input integer idx);
		ads_pkg::ads_op_e        op;
		ads_pkg::ads_byte_t      cmd;
		ads_pkg::ads_reg_addr_t  addr;
		ads_pkg::ads_byte_t      wdata;
		ads_pkg::ads_byte_t      miso;
		logic                    is_pin;
		integer                  frames0;
		integer                  falls0;
		integer                  pulses0;
		op     = ads_pkg::ads_op_e'(pat_mem[idx*FIELDS][1:0]);
		cmd    = pat_mem[idx*FIELDS+1];
		addr   = pat_mem[idx*FIELDS+2][4:0];
		wdata  = pat_mem[idx*FIELDS+3];
		miso   = pat_mem[idx*FIELDS+4];
		is_pin = (op == ads_pkg::ADS_OP_SYSCMD) && ((cmd == ads_pkg::CMD_START) ||
			(cmd == ads_pkg::CMD_STOP) || (cmd == ads_pkg::CMD_RESET));
		slave_miso = miso;
		repeat ($urandom_range(5, 0)) tick; // idle gap
		frames0 = frame_cnt;
		falls0  = csn_falls;
		pulses0 = reset_pulses;
		send_request(op, cmd, addr, wdata);
		check_bit("o_busy", o_busy, 1'b1);
		if (is_pin && (cmd != ads_pkg::CMD_RESET)) begin
			exp_start = (cmd == ads_pkg::CMD_START);
			check_bit("o_ads_start", o_ads_start, exp_start);
			tick;
			check_bit("o_busy", o_busy, 1'b0); // single busy cycle
		end else if (is_pin) begin
			check_bit("o_ads_resetn", o_ads_resetn, 1'b0);
		end
		if (rdata_pending) begin
			// start and stop are already done, spi frames and reset still busy
			stall_rdata($urandom_range(12, 2), !(is_pin && (cmd != ads_pkg::CMD_RESET)));
			take_rdata;
		end
		wait_idle;
		tick; // pin monitor settles
		check_bit("o_ads_start", o_ads_start, exp_start);
		check_bit("o_ads_resetn", o_ads_resetn, 1'b1);
		check_bit("o_spi_csn", o_spi_csn, 1'b1);
		check_bit("o_spi_clk", o_spi_clk, 1'b0); // sclk idles low
		if (is_pin) begin
			check_byte("o_spi_csn falls", 8'(csn_falls - falls0), 8'd0);
			check_byte("frame count", 8'(frame_cnt - frames0), 8'd0);
			if (cmd == ads_pkg::CMD_RESET) begin
				check_byte("o_ads_resetn pulses", 8'(reset_pulses - pulses0), 8'd1);
				check_byte("o_ads_resetn low cycles", 8'(last_reset_width),
					8'(ads_pkg::RESET_PULSE_CYCLES));
			end
		end else begin
			check_byte("o_spi_csn falls", 8'(csn_falls - falls0), 8'd1);
			check_byte("frame count", 8'(frame_cnt - frames0), 8'd1);
			if (op == ads_pkg::ADS_OP_SYSCMD) begin
				check_byte("frame length", frame_len, 8'd1);
				check_byte("o_spi_mosi byte 0", frame_bytes[7:0], cmd);
			end else begin
				check_byte("frame length", frame_len, 8'd3);
				check_byte("o_spi_mosi byte 0", frame_bytes[23:16], (op == ads_pkg::ADS_OP_WREG) ?
					{ads_pkg::OP_WREG_PREFIX, addr} : {ads_pkg::OP_RREG_PREFIX, addr});
				check_byte("o_spi_mosi byte 1", frame_bytes[15:8], ads_pkg::OP_REG_COUNT);
				check_byte("o_spi_mosi byte 2", frame_bytes[7:0],
					(op == ads_pkg::ADS_OP_WREG) ? wdata : 8'h00);
				if (op == ads_pkg::ADS_OP_RREG) begin
					exp_rdata     = miso; // left pending for the next request
					rdata_pending = 1'b1;
					check_bit("o_rdata_valid", o_rdata_valid, 1'b1);
					check_byte("o_rdata", o_rdata, exp_rdata);
				end
			end
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		seed_val      = $urandom(32'hd17cf567);
		i_CLK         = 1'b0;
		i_RSTN        = 1'b0;
		i_req_valid   = 1'b0;
		i_req_op      = ads_pkg::ADS_OP_SYSCMD;
		i_req_cmd     = 8'h00;
		i_req_addr    = 5'h00;
		i_req_wdata   = 8'h00;
		i_rdata_ready = 1'b0;
		slave_miso    = 8'h00;
		exp_start     = 1'b0;
		rdata_pending = 1'b0;
		exp_rdata     = 8'h00;
		$readmemh("ads_patterns.txt", pat_mem);
		if ($isunknown(pat_mem[PATTERN_COUNT*FIELDS-1])) begin
			abort_run("pattern file ads_patterns.txt is missing or has too few lines");
		end
		repeat (RESET_CYCLES) @(posedge i_CLK);
		#1;
		i_RSTN = 1'b1;
		check_bit("o_req_ready", o_req_ready, 1'b1);
		check_bit("o_busy", o_busy, 1'b0);
		check_bit("o_rdata_valid", o_rdata_valid, 1'b0);
		check_bit("o_ads_start", o_ads_start, 1'b0);
		check_bit("o_spi_clk", o_spi_clk, 1'b0);
		check_bit("o_spi_csn", o_spi_csn, 1'b1);
		check_bit("o_ads_resetn", o_ads_resetn, 1'b1);
		for (p = 0; p < PATTERN_COUNT; p = p + 1) begin
			run_pattern(p);
		end
		if (rdata_pending) begin
			stall_rdata($urandom_range(12, 2), 1'b0);
			take_rdata;
		end
		tick;
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_ads_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral ads1292 spi side, mode 1
// records mosi msb first, answers with one byte during the third byte
module tb_ads_spi_slave (
	input  wire                        i_spi_csn,
	input  wire                        i_spi_clk,
	input  wire                        i_spi_mosi,
	input  wire ads_pkg::ads_byte_t    i_miso_byte,   // sent during the third byte
	output logic                       o_spi_miso,
	output logic [23:0]                o_frame_bytes, // last three mosi bytes, newest low
	output logic [7:0]                 o_frame_len,   // whole bytes in the last frame
	output logic [7:0]                 o_frame_cnt    // completed frames
);

	logic        r_active = 1'b0; // inside a csn low period
	logic [23:0] r_shift;
	logic [2:0]  r_bit;           // bit within the byte
	logic [7:0]  r_bytes;         // whole bytes so far

	initial begin
		o_spi_miso    = 1'b0;
		o_frame_bytes = '0;
		o_frame_len   = '0;
		o_frame_cnt   = '0;
		r_shift       = '0;
		r_bit         = '0;
		r_bytes       = '0;
	end

	// frame start
	always @(negedge i_spi_csn) begin
		r_active = 1'b1;
		r_shift  = '0;
		r_bit    = '0;
		r_bytes  = '0;
	end

	// rising sclk, launch miso then pick up mosi once it has settled
	always @(posedge i_spi_clk) begin
		if (r_active) begin
			o_spi_miso = (r_bytes == 8'd2) ? i_miso_byte[3'd7 - r_bit] : 1'b0;
			#2; // mosi moves on the same system clock edge as sclk
			r_shift = {r_shift[22:0], i_spi_mosi};
			r_bit   = r_bit + 3'd1;
			if (r_bit == 3'd0) r_bytes = r_bytes + 8'd1; // byte complete
		end
	end

	// frame end, publish what was seen
	always @(posedge i_spi_csn) begin
		if (r_active) begin
			o_frame_bytes = r_shift;
			o_frame_len   = r_bytes;
			o_frame_cnt   = o_frame_cnt + 8'd1;
			o_spi_miso    = 1'b0;
			r_active      = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: ads_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ads_controller (
	input  wire                            i_CLK,
	input  wire                            i_RSTN,
	// host request
	input  wire                            i_req_valid,
	input  wire ads_pkg::ads_op_e          i_req_op,
	input  wire ads_pkg::ads_byte_t        i_req_cmd,
	input  wire ads_pkg::ads_reg_addr_t    i_req_addr,
	input  wire ads_pkg::ads_byte_t        i_req_wdata,
	output wire                            o_req_ready,
	output wire                            o_busy,
	// read data
	output wire ads_pkg::ads_byte_t        o_rdata,
	output wire                            o_rdata_valid,
	input  wire                            i_rdata_ready,
	// ads1292 pins
	output wire                            o_ads_start,
	output wire                            o_ads_resetn,
	output wire                            o_spi_clk,
	output wire                            o_spi_mosi,
	output wire                            o_spi_csn,
	input  wire                            i_spi_miso
);

	// builder to sequencer
	wire                       byte_valid;
	wire ads_pkg::ads_byte_t   byte_data;
	wire                       byte_last;
	wire                       byte_capture;
	wire                       byte_ready;
	wire                       frame_done;
	// sequencer to shifter
	wire                       tx_valid;
	wire ads_pkg::ads_byte_t   tx_byte;
	wire                       tx_ready;
	wire ads_pkg::ads_byte_t   rx_byte;
	wire                       rx_done;

	ads_frame_builder ads_frame_builder_inst (
		.i_CLK          (i_CLK),
		.i_RSTN         (i_RSTN),
		.i_req_valid    (i_req_valid),
		.i_req_op       (i_req_op),
		.i_req_cmd      (i_req_cmd),
		.i_req_addr     (i_req_addr),
		.i_req_wdata    (i_req_wdata),
		.o_req_ready    (o_req_ready),
		.o_busy         (o_busy),
		.o_ads_start    (o_ads_start),
		.o_ads_resetn   (o_ads_resetn),
		.o_byte_valid   (byte_valid),
		.o_byte_data    (byte_data),
		.o_byte_last    (byte_last),
		.o_byte_capture (byte_capture),
		.i_byte_ready   (byte_ready),
		.i_frame_done   (frame_done)
	);

	ads_cs_sequencer ads_cs_sequencer_inst (
		.i_CLK          (i_CLK),
		.i_RSTN         (i_RSTN),
		.i_byte_valid   (byte_valid),
		.i_byte_data    (byte_data),
		.i_byte_last    (byte_last),
		.i_byte_capture (byte_capture),
		.o_byte_ready   (byte_ready),
		.o_frame_done   (frame_done),
		.o_tx_valid     (tx_valid),
		.o_tx_byte      (tx_byte),
		.i_tx_ready     (tx_ready),
		.i_rx_byte      (rx_byte),
		.i_rx_done      (rx_done),
		.o_spi_csn      (o_spi_csn),
		.o_rdata        (o_rdata),
		.o_rdata_valid  (o_rdata_valid),
		.i_rdata_ready  (i_rdata_ready)
	);

	ads_spi_shifter ads_spi_shifter_inst (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_tx_valid (tx_valid),
		.i_tx_byte  (tx_byte),
		.o_tx_ready (tx_ready),
		.o_rx_byte  (rx_byte),
		.o_rx_done  (rx_done),
		.o_spi_clk  (o_spi_clk),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

endmodule

`default_nettype wire

// File: ads_spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

// spi master, mode 1
// sclk idles low, launch on rising edge, sample on falling edge, msb first
module ads_spi_shifter (
	input  wire                        i_CLK,
	input  wire                        i_RSTN,
	// byte in
	input  wire                        i_tx_valid,
	input  wire ads_pkg::ads_byte_t    i_tx_byte,
	output logic                       o_tx_ready, // idle only
	// byte out
	output ads_pkg::ads_byte_t         o_rx_byte,
	output logic                       o_rx_done,  // one cycle with o_rx_byte
	// spi pins
	output logic                       o_spi_clk,
	output logic                       o_spi_mosi,
	input  wire                        i_spi_miso
);

	logic                                  r_busy;
	logic [ads_pkg::HALF_BIT_CNT_W-1:0]    r_half_cnt; // clocks within a half bit
	logic [4:0]                            r_edge_cnt; // sclk edges left, 16 per byte
	ads_pkg::ads_byte_t                    r_tx_shift;
	ads_pkg::ads_byte_t                    r_rx_shift;
	logic                                  w_tick;     // sclk edge this cycle
	logic                                  w_start;

	assign o_tx_ready = ~r_busy;
	assign w_start    = o_tx_ready & i_tx_valid;
	assign w_tick     = r_busy & (r_half_cnt == ads_pkg::HALF_BIT_LAST);

	// ==================================================
	// clock generation and control
	// ==================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_busy     <= 1'b0;
			r_half_cnt <= '0;
			r_edge_cnt <= '0;
			o_spi_clk  <= 1'b0; // cpol 0
			o_spi_mosi <= 1'b0;
			o_rx_done  <= 1'b0;
		end else begin
			o_rx_done <= 1'b0;
			if (!r_busy) begin
				if (i_tx_valid) begin
					r_busy     <= 1'b1;
					r_half_cnt <= '0;
					r_edge_cnt <= 5'd16;
				end
			end else if (w_tick) begin
				r_half_cnt <= '0;
				o_spi_clk  <= ~o_spi_clk;
				r_edge_cnt <= r_edge_cnt - 1'b1;
				if (!o_spi_clk) begin
					o_spi_mosi <= r_tx_shift[7]; // rising edge, launch
				end else if (r_edge_cnt == 5'd1) begin
					// last falling edge, byte complete
					r_busy     <= 1'b0;
					o_rx_done  <= 1'b1;
					o_spi_mosi <= 1'b0;
				end
			end else begin
				r_half_cnt <= r_half_cnt + 1'b1;
			end
		end
	end

	// ==================================================
	// shift registers
	// ==================================================
	always_ff @(posedge i_CLK) begin
		if (w_start) begin
			r_tx_shift <= i_tx_byte;
		end else if (w_tick & ~o_spi_clk) begin
			r_tx_shift <= {r_tx_shift[6:0], 1'b0}; // next bit up
		end
		if (w_tick & o_spi_clk) begin
			// falling edge, sample miso
			r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};
			if (r_edge_cnt == 5'd1) o_rx_byte <= {r_rx_shift[6:0], i_spi_miso};
		end
	end

endmodule

`default_nettype wire

// File: ads_cs_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ads_cs_sequencer (
	input  wire                        i_CLK,
	input  wire                        i_RSTN,
	// byte stream from the frame builder
	input  wire                        i_byte_valid,
	input  wire ads_pkg::ads_byte_t    i_byte_data,
	input  wire                        i_byte_last,
	input  wire                        i_byte_capture,
	output logic                       o_byte_ready,
	output logic                       o_frame_done, // one cycle, csn already high
	// shifter side
	output logic                       o_tx_valid,
	output ads_pkg::ads_byte_t         o_tx_byte,
	input  wire                        i_tx_ready,
	input  wire ads_pkg::ads_byte_t    i_rx_byte,
	input  wire                        i_rx_done,
	output logic                       o_spi_csn,
	// read data to host
	output ads_pkg::ads_byte_t         o_rdata,
	output logic                       o_rdata_valid,
	input  wire                        i_rdata_ready
);

	typedef enum logic [1:0] {
		ST_IDLE,   // csn high
		ST_SELECT, // csn low, between bytes
		ST_XFER,   // byte on the wire
		ST_HOLD    // csn hold after last edge
	} state_e;

	state_e                              r_state;
	logic                                r_last;    // byte in flight ends the frame
	logic                                r_capture; // byte in flight goes to the host
	logic [ads_pkg::CS_HOLD_CNT_W-1:0]   r_hold_cnt;
	logic                                w_byte_fire;
	logic                                w_capture_fire;

	// no new byte while read data is still pending
	assign o_byte_ready   = ((r_state == ST_IDLE) | (r_state == ST_SELECT)) & ~o_rdata_valid;
	assign w_byte_fire    = i_byte_valid & o_byte_ready;
	assign w_capture_fire = i_rx_done & r_capture & (r_state == ST_XFER);

	always_ff @(posedge i_CLK) begin
		if (w_byte_fire) o_tx_byte <= i_byte_data;
	end

	// ==================================================
	// chip select fsm
	// ==================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state      <= ST_IDLE;
			r_last       <= 1'b0;
			r_capture    <= 1'b0;
			r_hold_cnt   <= '0;
			o_spi_csn    <= 1'b1;
			o_tx_valid   <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			if (o_tx_valid & i_tx_ready) o_tx_valid <= 1'b0; // shifter took it
			case (r_state)
				ST_IDLE, ST_SELECT: begin
					if (w_byte_fire) begin
						o_spi_csn  <= 1'b0; // low from the next cycle on
						o_tx_valid <= 1'b1;
						r_last     <= i_byte_last;
						r_capture  <= i_byte_capture;
						r_state    <= ST_XFER;
					end
				end
				ST_XFER: begin
					if (i_rx_done) begin
						r_hold_cnt <= '0;
						r_state    <= r_last ? ST_HOLD : ST_SELECT;
					end
				end
				ST_HOLD: begin
					if (r_hold_cnt == ads_pkg::CS_HOLD_LAST) begin
						o_spi_csn    <= 1'b1;
						o_frame_done <= 1'b1;
						r_state      <= ST_IDLE;
					end else begin
						r_hold_cnt <= r_hold_cnt + 1'b1;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// ==================================================
	// read-back register
	// ==================================================
	always_ff @(posedge i_CLK) begin
		if (w_capture_fire) o_rdata <= i_rx_byte;
	end

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			o_rdata_valid <= 1'b0;
		end else if (w_capture_fire) begin
			o_rdata_valid <= 1'b1;
		end else if (o_rdata_valid & i_rdata_ready) begin
			o_rdata_valid <= 1'b0; // host took it
		end
	end

endmodule

`default_nettype wire

// File: ads_frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module ads_frame_builder (
	input  wire                            i_CLK,
	input  wire                            i_RSTN,
	// host request
	input  wire                            i_req_valid,
	input  wire ads_pkg::ads_op_e          i_req_op,
	input  wire ads_pkg::ads_byte_t        i_req_cmd,
	input  wire ads_pkg::ads_reg_addr_t    i_req_addr,
	input  wire ads_pkg::ads_byte_t        i_req_wdata,
	output logic                           o_req_ready,
	output logic                           o_busy,
	// chip pins
	output logic                           o_ads_start,
	output logic                           o_ads_resetn, // active low
	// byte stream to the cs sequencer
	output logic                           o_byte_valid,
	output ads_pkg::ads_byte_t             o_byte_data,
	output logic                           o_byte_last,    // closes the frame
	output logic                           o_byte_capture, // keep the miso byte
	input  wire                            i_byte_ready,
	input  wire                            i_frame_done    // csn back high
);

	typedef enum logic [2:0] {
		ST_IDLE,      // waiting for a request
		ST_PIN,       // pin action, reset pulse or single busy cycle
		ST_EMIT0,     // opcode or {prefix, addr}
		ST_EMIT1,     // register count
		ST_EMIT2,     // write data or dummy
		ST_WAIT_DONE  // frame in flight
	} state_e;

	state_e                                r_state;
	ads_pkg::ads_op_e                      r_op;
	ads_pkg::ads_byte_t                    r_cmd;
	ads_pkg::ads_byte_t                    r_wdata;
	ads_pkg::ads_reg_addr_t                r_addr;
	logic [ads_pkg::RESET_CNT_W-1:0]       r_pin_cnt;
	logic                                  w_req_fire;
	logic                                  w_byte_fire;

	assign o_req_ready = ~o_busy;
	assign w_req_fire  = i_req_valid & o_req_ready;
	assign w_byte_fire = o_byte_valid & i_byte_ready;

	// request fields
	always_ff @(posedge i_CLK) begin
		if (w_req_fire) begin
			r_cmd   <= i_req_cmd;
			r_addr  <= i_req_addr;
			r_wdata <= i_req_wdata;
		end
	end

	// ==================================================
	// request fsm
	// ==================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state      <= ST_IDLE;
			r_op         <= ads_pkg::ADS_OP_SYSCMD;
			r_pin_cnt    <= '0;
			o_busy       <= 1'b0;
			o_ads_start  <= 1'b0;
			o_ads_resetn <= 1'b1; // chip out of reset
		end else begin
			case (r_state)
				ST_IDLE: begin
					if (w_req_fire) begin
						o_busy    <= 1'b1;
						r_op      <= i_req_op;
						r_pin_cnt <= '0;
						r_state   <= ST_EMIT0; // spi unless a pin opcode
						if (i_req_op == ads_pkg::ADS_OP_SYSCMD) begin
							if (i_req_cmd == ads_pkg::CMD_START) begin
								o_ads_start <= 1'b1;
								r_pin_cnt   <= ads_pkg::RESET_LAST; // one busy cycle
								r_state     <= ST_PIN;
							end else if (i_req_cmd == ads_pkg::CMD_STOP) begin
								o_ads_start <= 1'b0;
								r_pin_cnt   <= ads_pkg::RESET_LAST;
								r_state     <= ST_PIN;
							end else if (i_req_cmd == ads_pkg::CMD_RESET) begin
								o_ads_resetn <= 1'b0; // full pulse length
								r_state      <= ST_PIN;
							end
						end
					end
				end
				ST_PIN: begin
					if (r_pin_cnt == ads_pkg::RESET_LAST) begin
						o_ads_resetn <= 1'b1;
						o_busy       <= 1'b0;
						r_state      <= ST_IDLE;
					end else begin
						r_pin_cnt <= r_pin_cnt + 1'b1;
					end
				end
				ST_EMIT0: begin
					if (w_byte_fire) begin
						// a plain opcode is a one byte frame
						r_state <= (r_op == ads_pkg::ADS_OP_SYSCMD) ? ST_WAIT_DONE : ST_EMIT1;
					end
				end
				ST_EMIT1: if (w_byte_fire) r_state <= ST_EMIT2;
				ST_EMIT2: if (w_byte_fire) r_state <= ST_WAIT_DONE;
				ST_WAIT_DONE: begin
					if (i_frame_done) begin
						o_busy  <= 1'b0; // falls one cycle after frame_done
						r_state <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// byte stream, straight from state and latched request
	always_comb begin
		o_byte_valid   = 1'b0;
		o_byte_data    = 8'h00;
		o_byte_last    = 1'b0;
		o_byte_capture = 1'b0;
		case (r_state)
			ST_EMIT0: begin
				o_byte_valid = 1'b1;
				case (r_op)
					ads_pkg::ADS_OP_WREG: o_byte_data = {ads_pkg::OP_WREG_PREFIX, r_addr};
					ads_pkg::ADS_OP_RREG: o_byte_data = {ads_pkg::OP_RREG_PREFIX, r_addr};
					default: begin
						o_byte_data = r_cmd;
						o_byte_last = 1'b1;
					end
				endcase
			end
			ST_EMIT1: begin
				o_byte_valid = 1'b1;
				o_byte_data  = ads_pkg::OP_REG_COUNT;
			end
			ST_EMIT2: begin
				o_byte_valid   = 1'b1;
				o_byte_last    = 1'b1;
				o_byte_data    = (r_op == ads_pkg::ADS_OP_WREG) ? r_wdata : 8'h00; // dummy on read
				o_byte_capture = (r_op == ads_pkg::ADS_OP_RREG);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: ads_pkg.sv
`default_nettype none

package ads_pkg;

	// ==================================================
	// host request types
	// ==================================================
	typedef enum logic [1:0] {
		ADS_OP_SYSCMD = 2'd0, // one opcode byte or a pin action
		ADS_OP_WREG   = 2'd1, // write one register
		ADS_OP_RREG   = 2'd2  // read one register
	} ads_op_e;

	typedef logic [7:0] ads_byte_t;     // one spi byte
	typedef logic [4:0] ads_reg_addr_t; // rrrrr field of the first opcode byte

	// ==================================================
	// opcodes
	// ==================================================
	localparam ads_byte_t CMD_RESET = 8'h06; // pulses the reset pin
	localparam ads_byte_t CMD_START = 8'h08; // start pin high
	localparam ads_byte_t CMD_STOP  = 8'h0A; // start pin low

	// register access, first byte is {prefix, addr}
	localparam logic [2:0] OP_RREG_PREFIX = 3'b001;
	localparam logic [2:0] OP_WREG_PREFIX = 3'b010;
	localparam ads_byte_t  OP_REG_COUNT   = 8'h00; // n-1 with n = 1

	// ==================================================
	// timing
	// ==================================================
	localparam integer CLKS_PER_HALF_BIT  = 4;  // sclk = clk / 8
	localparam integer CS_HOLD_CYCLES     = 8;  // csn low after last sclk edge
	localparam integer RESET_PULSE_CYCLES = 16; // resetn low time

	// counter widths and terminal values
	localparam integer HALF_BIT_CNT_W = $clog2(CLKS_PER_HALF_BIT);
	localparam integer CS_HOLD_CNT_W  = $clog2(CS_HOLD_CYCLES);
	localparam integer RESET_CNT_W    = $clog2(RESET_PULSE_CYCLES);
	localparam logic [HALF_BIT_CNT_W-1:0] HALF_BIT_LAST = HALF_BIT_CNT_W'(CLKS_PER_HALF_BIT - 1);
	localparam logic [CS_HOLD_CNT_W-1:0]  CS_HOLD_LAST  = CS_HOLD_CNT_W'(CS_HOLD_CYCLES - 1);
	localparam logic [RESET_CNT_W-1:0]    RESET_LAST    = RESET_CNT_W'(RESET_PULSE_CYCLES - 1);

endpackage

`default_nettype wire
